// File: src/obj_video_pkg.sv
// Video timing and sprite geometry types
// Pixel, colour index and ROM address widths

package obj_video_pkg;

    // Raster line number, also sprite Y
    typedef logic [7:0] vpos_t;

    // Horizontal dump position, also sprite X
    // Only 0 to 255 are visible
    typedef logic [8:0] hpos_t;

    // Raw sprite pixel, 0 is transparent
    typedef logic [3:0] pix_t;

    // Palette bank from the attribute byte
    typedef logic [3:0] pal_t;

    // Colour index {bank, pixel}
    typedef logic [7:0] cidx_t;

    // Sprite code, bit 8 comes from the attribute
    typedef logic [8:0] code_t;

    // Graphics ROM word address {code, row, half}
    typedef logic [13:0] rom_addr_t;

    // Object table entry number
    typedef logic [4:0] obj_idx_t;

    // Sprites are square
    localparam int OBJ_H = 16;

endpackage

// File: src/obj_bus_pkg.sv
// Packed structs passed between the sprite engine blocks
// CPU table access, draw request and line buffer write

package obj_bus_pkg;

    import obj_video_pkg::*;

    // CPU byte access to the object table
    typedef struct packed {
        logic [6:0] addr;
        logic [7:0] wdata;
        logic       we;
    } cpu_bus_t;

    // One matched sprite, from the scan FSM to the draw datapath
    typedef struct packed {
        code_t      code;
        hpos_t      xpos;
        pal_t       pal;
        logic       hflip;
        logic       vflip;
        logic [3:0] row;    // already vflip corrected
    } draw_req_t;

    // Single pixel write into the draw bank
    typedef struct packed {
        logic [7:0] addr;
        cidx_t      data;
        logic       we;
    } lbuf_wr_t;

endpackage

// File: src/obj_table_ram.sv
// Object table RAM
// CPU read/write port plus a read-only scan port

`timescale 1ns/1ps

module obj_table_ram import obj_bus_pkg::*; #(
    parameter int MAX_OBJ = 32
) (
    input  logic       clk,
    input  cpu_bus_t   cpu,
    output logic [7:0] cpu_rdata,
    input  logic [6:0] scan_addr,
    output logic [7:0] scan_rdata
);

    // Four bytes per entry
    localparam int DEPTH = 4 * MAX_OBJ;

    logic [7:0] mem [DEPTH];

    // CPU side, read before write
    always_ff @(posedge clk) begin
        if (cpu.we) begin
            mem[cpu.addr] <= cpu.wdata;
        end
        cpu_rdata <= mem[cpu.addr];
    end

    // Scan side, read only
    always_ff @(posedge clk) begin
        scan_rdata <= mem[scan_addr];
    end

endmodule

// File: src/obj_scan.sv
// Object table scan FSM
// Walks all entries once per line and issues draw requests

`timescale 1ns/1ps

module obj_scan import obj_video_pkg::*, obj_bus_pkg::*; #(
    parameter int MAX_OBJ = 32
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       hinit,
    input  vpos_t      vrender,
    output logic [6:0] scan_addr,
    input  logic [7:0] scan_rdata,
    input  logic       busy,
    output logic       draw,
    output draw_req_t  req
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_Y,
        S_RD_ATTR,
        S_RD_CODE,
        S_RD_X,
        S_DECIDE,
        S_WAIT
    } scan_st_t;

    localparam obj_idx_t LAST_IDX = obj_idx_t'(MAX_OBJ - 1);

    scan_st_t   st;
    obj_idx_t   idx;
    logic [1:0] byte_sel;

    // Captured entry bytes
    vpos_t      y_q;
    logic [7:0] attr_q;
    logic [7:0] code_q;

    // Match rule
    vpos_t      ydiff;
    logic       inzone;
    logic [3:0] row;

    assign ydiff  = vrender - y_q;
    assign inzone = ydiff < vpos_t'(OBJ_H);
    // vflip mirrors the row inside the sprite
    assign row    = ydiff[3:0] ^ {4{attr_q[7]}};

    // Byte offset presented by each read state
    always_comb begin
        case (st)
            S_RD_ATTR: byte_sel = 2'd1;
            S_RD_CODE: byte_sel = 2'd2;
            S_RD_X:    byte_sel = 2'd3;
            default:   byte_sel = 2'd0;
        endcase
    end

    assign scan_addr = {idx, byte_sel};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st   <= S_IDLE;
            idx  <= '0;
            draw <= 1'b0;
        end else begin
            draw <= 1'b0;
            case (st)
                S_IDLE: begin
                    if (hinit) begin
                        idx <= '0;
                        st  <= S_RD_Y;
                    end
                end
                S_RD_Y:    st <= S_RD_ATTR;
                S_RD_ATTR: st <= S_RD_CODE;
                S_RD_CODE: st <= S_RD_X;
                S_RD_X:    st <= S_DECIDE;
                S_DECIDE: begin
                    if (inzone) begin
                        draw <= 1'b1;
                        st   <= S_WAIT;
                    end else if (idx == LAST_IDX) begin
                        st <= S_IDLE;
                    end else begin
                        idx <= idx + 1'b1;
                        st  <= S_RD_Y;
                    end
                end
                S_WAIT: begin
                    // busy only rises the cycle after draw
                    if (!draw && !busy) begin
                        if (idx == LAST_IDX) begin
                            st <= S_IDLE;
                        end else begin
                            idx <= idx + 1'b1;
                            st  <= S_RD_Y;
                        end
                    end
                end
                default: st <= S_IDLE;
            endcase
        end
    end

    // Data for each byte lands one state after its address
    always_ff @(posedge clk) begin
        case (st)
            S_RD_ATTR: y_q    <= scan_rdata;
            S_RD_CODE: attr_q <= scan_rdata;
            S_RD_X:    code_q <= scan_rdata;
            default: ;
        endcase
        if (st == S_DECIDE && inzone) begin
            // X byte arrives in the decide cycle
            req.code  <= {attr_q[4], code_q};
            req.xpos  <= {1'b0, scan_rdata};
            req.pal   <= attr_q[3:0];
            req.hflip <= attr_q[6];
            req.vflip <= attr_q[7];
            req.row   <= row;
        end
    end

endmodule

// File: src/obj_draw.sv
// Sprite draw datapath
// Graphics ROM fetch per half and pixel plotting into the line buffer

`timescale 1ns/1ps

module obj_draw import obj_video_pkg::*, obj_bus_pkg::*; #(
    parameter logic [7:0] HOFFSET = 8'd0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        draw,
    input  draw_req_t   req,
    output logic        busy,
    output rom_addr_t   rom_addr,
    output logic        rom_cs,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    output lbuf_wr_t    lbuf_wr
);

    typedef enum logic [1:0] {
        D_IDLE,
        D_FETCH,
        D_PLOT
    } draw_st_t;

    // Eight pixels per ROM word
    localparam logic [2:0] LAST_COL = 3'(OBJ_H / 2 - 1);

    draw_st_t    st;
    draw_req_t   req_q;
    logic        half;
    logic [2:0]  col;
    logic [31:0] word_q;

    pix_t        pix;
    logic [3:0]  scr_col;
    logic [7:0]  plot_x;

    // Registered line buffer write
    logic        wr_we;
    logic [7:0]  wr_addr;
    cidx_t       wr_data;

    assign busy     = st != D_IDLE;
    assign rom_cs   = st == D_FETCH;
    // Address held while the fetch state waits for rom_ok
    assign rom_addr = {req_q.code, req_q.row, half};

    // Pixel col of the current half, lowest nibble first
    assign pix     = word_q[{col, 2'b00} +: 4];
    // hflip reverses the sixteen columns
    assign scr_col = {half, col} ^ {4{req_q.hflip}};
    // Wraps around the 256 pixel line
    assign plot_x  = req_q.xpos[7:0] + HOFFSET + {4'd0, scr_col};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st    <= D_IDLE;
            half  <= 1'b0;
            col   <= '0;
            wr_we <= 1'b0;
        end else begin
            // Transparent pixels are never written
            wr_we <= st == D_PLOT && pix != '0;
            case (st)
                D_IDLE: begin
                    if (draw) begin
                        half <= 1'b0;
                        st   <= D_FETCH;
                    end
                end
                D_FETCH: begin
                    if (rom_ok) begin
                        col <= '0;
                        st  <= D_PLOT;
                    end
                end
                D_PLOT: begin
                    col <= col + 1'b1;
                    if (col == LAST_COL) begin
                        if (half) begin
                            st <= D_IDLE;
                        end else begin
                            half <= 1'b1;
                            st   <= D_FETCH;
                        end
                    end
                end
                default: st <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == D_IDLE && draw) begin
            req_q <= req;
        end
        if (st == D_FETCH && rom_ok) begin
            word_q <= rom_data;
        end
        wr_addr <= plot_x;
        wr_data <= {req_q.pal, pix};
    end

    assign lbuf_wr = '{addr: wr_addr, data: wr_data, we: wr_we};

endmodule

// File: src/obj_line_buf.sv
// Ping-pong sprite line buffer
// Draw bank written by the datapath, read bank read out and cleared

`timescale 1ns/1ps

module obj_line_buf import obj_video_pkg::*, obj_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     hinit,
    input  lbuf_wr_t lbuf_wr,
    input  logic     pxl_cen,
    input  logic     lhbl,
    input  hpos_t    hdump,
    output cidx_t    rd_cidx
);

    logic       bank;       // bank being drawn
    logic       rd_en;
    logic [7:0] rd_addr;
    cidx_t      bank_q [2];
    cidx_t      rd_q;
    cidx_t      rd_hold;

    assign rd_en   = pxl_cen & lhbl;
    assign rd_addr = hdump[7:0];
    assign rd_q    = bank_q[~bank];

    // Swap banks at every line start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
        end else if (hinit) begin
            bank <= ~bank;
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        cidx_t mem [256];

        always_ff @(posedge clk) begin
            if (bank == 1'(b)) begin
                if (lbuf_wr.we) begin
                    mem[lbuf_wr.addr] <= lbuf_wr.data;
                end
            end else if (rd_en) begin
                // Read then clear, empty for the next draw turn
                mem[rd_addr] <= '0;
            end
        end

        assign bank_q[b] = mem[rd_addr];
    end

    // Keep the pixel steady between pixel enables
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_hold <= '0;
        end else if (rd_en) begin
            rd_hold <= rd_q;
        end
    end

    assign rd_cidx = rd_en ? rd_q : rd_hold;

endmodule

// File: src/obj_pal_prom.sv
// Palette PROM, loaded through the programming port
// Registered pixel output, blanked outside the active line

`timescale 1ns/1ps

module obj_pal_prom import obj_video_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cidx_t      prog_addr,
    input  logic [3:0] prog_data,
    input  logic       prog_en,
    input  cidx_t      cidx,
    input  logic       lhbl,
    output logic [3:0] pxl
);

    logic [3:0] prom [256];

    // Loaded once at start up
    always_ff @(posedge clk) begin
        if (prog_en) begin
            prom[prog_addr] <= prog_data;
        end
    end

    // Lookup registered, zero in blank
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= '0;
        end else begin
            pxl <= lhbl ? prom[cidx] : 4'd0;
        end
    end

endmodule

// File: src/obj_engine.sv
// Sprite engine top level
// Object table, scan FSM, draw datapath, line buffer and palette

`timescale 1ns/1ps

module obj_engine import obj_video_pkg::*, obj_bus_pkg::*; #(
    parameter int         MAX_OBJ = 32,
    parameter logic [7:0] HOFFSET = 8'd0
) (
    input  logic        clk,
    input  logic        rst,
    // CPU port
    input  logic [6:0]  cpu_addr,
    input  logic [7:0]  cpu_dout,
    input  logic        obj_cs,
    input  logic        cpu_rnw,
    output logic [7:0]  obj_dout,
    // Video timing
    input  logic        hinit,
    input  logic        lhbl,
    input  vpos_t       vrender,
    input  hpos_t       hdump,
    input  logic        pxl_cen,
    // Palette PROM load
    input  cidx_t       prog_addr,
    input  logic [3:0]  prog_data,
    input  logic        prog_en,
    // Graphics ROM
    output rom_addr_t   rom_addr,
    output logic        rom_cs,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    output logic [3:0]  pxl
);

    cpu_bus_t   cpu;
    logic [6:0] scan_addr;
    logic [7:0] scan_rdata;
    logic       draw;
    logic       busy;
    draw_req_t  req;
    lbuf_wr_t   lbuf_wr;
    cidx_t      rd_cidx;

    // Write only when selected and not reading
    assign cpu = '{addr: cpu_addr, wdata: cpu_dout, we: obj_cs & ~cpu_rnw};

    obj_table_ram #(.MAX_OBJ(MAX_OBJ)) i_table (
        .clk        (clk),
        .cpu        (cpu),
        .cpu_rdata  (obj_dout),
        .scan_addr  (scan_addr),
        .scan_rdata (scan_rdata)
    );

    obj_scan #(.MAX_OBJ(MAX_OBJ)) i_scan (
        .clk        (clk),
        .rst        (rst),
        .hinit      (hinit),
        .vrender    (vrender),
        .scan_addr  (scan_addr),
        .scan_rdata (scan_rdata),
        .busy       (busy),
        .draw       (draw),
        .req        (req)
    );

    obj_draw #(.HOFFSET(HOFFSET)) i_draw (
        .clk      (clk),
        .rst      (rst),
        .draw     (draw),
        .req      (req),
        .busy     (busy),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .lbuf_wr  (lbuf_wr)
    );

    obj_line_buf i_lbuf (
        .clk     (clk),
        .rst     (rst),
        .hinit   (hinit),
        .lbuf_wr (lbuf_wr),
        .pxl_cen (pxl_cen),
        .lhbl    (lhbl),
        .hdump   (hdump),
        .rd_cidx (rd_cidx)
    );

    obj_pal_prom i_pal (
        .clk       (clk),
        .rst       (rst),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .cidx      (rd_cidx),
        .lhbl      (lhbl),
        .pxl       (pxl)
    );

endmodule

// File: verif/tb_clk_gen.sv
// Testbench clock and reset generator

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset released just after a rising edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

// File: verif/tb_obj_engine.sv
// Sprite engine testbench
// Random table and ROM model, video timing driver, reference line model

`timescale 1ns/1ps

module tb_obj_engine import obj_video_pkg::*; ();

    localparam logic [7:0] HOFF = 8'd3;
    // Video lines run by all tests together
    localparam int LINES = 4 + 6 * 17 + 20 + 40;
    localparam int LIMIT = LINES * 1024 + 2000;

    logic        clk;
    logic        rst;
    logic [6:0]  cpu_addr;
    logic [7:0]  cpu_dout;
    logic        obj_cs;
    logic        cpu_rnw;
    logic [7:0]  obj_dout;
    logic        hinit;
    logic        lhbl;
    vpos_t       vrender;
    hpos_t       hdump;
    logic        pxl_cen;
    cidx_t       prog_addr;
    logic [3:0]  prog_data;
    logic        prog_en;
    rom_addr_t   rom_addr;
    logic        rom_cs;
    logic [31:0] rom_data;
    logic        rom_ok;
    logic [3:0]  pxl;

    integer     seed;
    int         errors;
    int         checks;
    int         cycles;
    logic [7:0] tbl [128];
    logic [3:0] prom_copy [256];
    logic [3:0] exp_cur [256];
    logic [3:0] exp_nxt [256];
    // ROM model state
    int         max_lat;
    int         rom_cnt;
    bit         no_rom;
    bit         prev_wait;
    rom_addr_t  prev_addr;

    tb_clk_gen #(.PERIOD(20), .RST_CYCLES(8)) i_clk (
        .clk (clk),
        .rst (rst)
    );

    obj_engine #(.MAX_OBJ(32), .HOFFSET(HOFF)) i_dut (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .obj_cs    (obj_cs),
        .cpu_rnw   (cpu_rnw),
        .obj_dout  (obj_dout),
        .hinit     (hinit),
        .lhbl      (lhbl),
        .vrender   (vrender),
        .hdump     (hdump),
        .pxl_cen   (pxl_cen),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .pxl       (pxl)
    );

    function automatic logic [7:0] rand_byte();
        return 8'($random(seed));
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Graphics ROM contents, a hash of the word address
    function automatic logic [31:0] rom_hash(input rom_addr_t a);
        logic [31:0] h;
        h = {18'd0, a} * 32'h9e3779b1;
        h = h ^ (h >> 13) ^ 32'h5bd1e995;
        return h;
    endfunction

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report(input string name, input int c0, input int e0);
        $display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    // Expected output of the line drawn with vrender v
    task automatic model_line(input vpos_t v);
        cidx_t       line_idx [256];
        vpos_t       diff;
        logic [7:0]  at;
        logic [3:0]  row;
        code_t       code;
        logic        hf;
        logic [31:0] w;
        pix_t        p;
        logic [7:0]  sx;
        for (int i = 0; i < 256; i++) line_idx[i] = '0;
        // Entry order, later entries overwrite
        for (int e = 0; e < 32; e++) begin
            diff = v - tbl[4 * e];
            at   = tbl[4 * e + 1];
            if (diff < 8'd16) begin
                row  = at[7] ? 4'd15 - diff[3:0] : diff[3:0];
                code = {at[4], tbl[4 * e + 2]};
                for (int k = 0; k < 16; k++) begin
                    hf = (k >= 8);
                    w  = rom_hash({code, row, hf});
                    p  = w[4 * (k % 8) +: 4];
                    sx = tbl[4 * e + 3] + HOFF + 8'(at[6] ? 15 - k : k);
                    if (p != 4'd0) line_idx[sx] = {at[3:0], p};
                end
            end
        end
        for (int i = 0; i < 256; i++) exp_nxt[i] = prom_copy[line_idx[i]];
    endtask

    // One 1024 clk line, hinit at the start of blank, visible half last
    task automatic run_line(input vpos_t v, input bit chk);
        int x;
        model_line(v);
        for (int c = 0; c < 1024; c++) begin
            @(posedge clk);
            #2;
            hinit   = (c == 0);
            pxl_cen = (c % 2 == 0);
            hdump   = hpos_t'((c / 2 + 256) % 512);
            lhbl    = (hdump < 9'd256);
            vrender = v;
            // Pixel x sampled mid cycle after its pxl_cen cycle
            if (chk && c >= 513 && c % 2 == 1) begin
                #8;
                x = (c - 513) / 2;
                check_val(32'(pxl), 32'(exp_cur[x]), $sformatf("pixel %0d line %0d", x, 8'(v - 1)));
            end
        end
        exp_cur = exp_nxt;
    endtask

    task automatic cpu_write(input logic [6:0] a, input logic [7:0] d);
        @(posedge clk);
        #2;
        cpu_addr = a;
        cpu_dout = d;
        obj_cs   = 1'b1;
        cpu_rnw  = 1'b0;
        tbl[a]   = d;
    endtask

    task automatic cpu_read_check(input logic [6:0] a);
        @(posedge clk);
        #2;
        cpu_addr = a;
        obj_cs   = 1'b1;
        cpu_rnw  = 1'b1;
        @(posedge clk);
        #8;
        check_val(32'(obj_dout), 32'(tbl[a]), $sformatf("obj_dout at %0d", a));
    endtask

    task automatic prom_write(input cidx_t a, input logic [3:0] d);
        @(posedge clk);
        #2;
        prog_addr    = a;
        prog_data    = d;
        prog_en      = 1'b1;
        prom_copy[a] = d;
    endtask

    // Ends any CPU or PROM access in progress
    task automatic bus_idle();
        @(posedge clk);
        #2;
        obj_cs  = 1'b0;
        cpu_rnw = 1'b1;
        prog_en = 1'b0;
    endtask

    // ROM model with random latency, plus address hold check
    always @(posedge clk) begin
        if (rom_cs && prev_wait)
            check_val(32'(rom_addr), 32'(prev_addr), "rom_addr during stall");
        if (no_rom)
            check_val(32'(rom_cs), 32'd0, "rom_cs with no sprite in range");
        prev_wait = rom_cs && !rom_ok;
        prev_addr = rom_addr;
        if (rom_ok) begin
            #2;
            rom_ok  = 1'b0;
            rom_cnt = 0;
        end else if (rom_cs) begin
            if (rom_cnt == 0) rom_cnt = 1 + rand_below(max_lat);
            rom_cnt--;
            if (rom_cnt == 0) begin
                #2;
                rom_data = rom_hash(rom_addr);
                rom_ok   = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: no result after %0d cycles", LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int         c0;
        int         e0;
        vpos_t      base;
        int         sel;
        cpu_addr  = '0;
        cpu_dout  = '0;
        obj_cs    = 1'b0;
        cpu_rnw   = 1'b1;
        hinit     = 1'b0;
        lhbl      = 1'b0;
        vrender   = '0;
        hdump     = '0;
        pxl_cen   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_en   = 1'b0;
        rom_data  = '0;
        rom_ok    = 1'b0;
        seed      = 32'hf043;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        max_lat   = 1;
        rom_cnt   = 0;
        no_rom    = 1'b0;
        prev_wait = 1'b0;

        // Quiet outputs through reset and before any line
        c0 = checks;
        e0 = errors;
        @(negedge clk);
        while (rst) begin
            check_val(32'(pxl), 32'd0, "pxl in reset");
            check_val(32'(rom_cs), 32'd0, "rom_cs in reset");
            @(negedge clk);
        end
        repeat (16) begin
            @(negedge clk);
            check_val(32'(pxl), 32'd0, "pxl before first line");
            check_val(32'(rom_cs), 32'd0, "rom_cs before first line");
        end
        report("reset state", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int a = 0; a < 128; a++) cpu_write(7'(a), rand_byte());
        bus_idle();
        for (int a = 0; a < 128; a++) cpu_read_check(7'(a));
        bus_idle();
        report("cpu readback", c0, e0);

        // Y of 128 never matches lines 0 to 3
        c0 = checks;
        e0 = errors;
        for (int p = 0; p < 256; p++) prom_write(cidx_t'(p), 4'(rand_byte()));
        for (int e = 0; e < 32; e++) cpu_write(7'(4 * e), 8'd128);
        bus_idle();
        no_rom = 1'b1;
        // First two lines flush unknown line buffer contents
        for (int v = 0; v < 4; v++) run_line(vpos_t'(v), v >= 2);
        no_rom = 1'b0;
        report("prom programming", c0, e0);

        c0 = checks;
        e0 = errors;
        max_lat = 4;
        for (int s = 0; s < 6; s++) begin
            base = rand_byte();
            sel  = rand_below(32);
            for (int e = 0; e < 32; e++) cpu_write(7'(4 * e), base + 8'd64);
            cpu_write(7'(4 * sel), base);
            cpu_write(7'(4 * sel + 1), rand_byte());
            cpu_write(7'(4 * sel + 2), rand_byte());
            cpu_write(7'(4 * sel + 3), rand_byte());
            bus_idle();
            // Extra line so the last sprite row is read out
            for (int r = 0; r < 17; r++) run_line(base + 8'(r), 1'b1);
        end
        report("single sprites", c0, e0);

        // Crowded lines need the short ROM latency to fit
        c0 = checks;
        e0 = errors;
        max_lat = 1;
        base = rand_byte();
        for (int e = 0; e < 32; e++) begin
            cpu_write(7'(4 * e), base - 8'(rand_below(12)));
            cpu_write(7'(4 * e + 1), rand_byte());
            cpu_write(7'(4 * e + 2), rand_byte());
            cpu_write(7'(4 * e + 3), 8'(96 + rand_below(32)));
        end
        bus_idle();
        for (int r = 0; r < 20; r++) run_line(base + 8'(r), 1'b1);
        report("overlap priority", c0, e0);

        c0 = checks;
        e0 = errors;
        max_lat = 4;
        base = rand_byte();
        for (int e = 0; e < 32; e++) cpu_write(7'(4 * e), base + 8'd128);
        for (int n = 0; n < 8; n++) begin
            sel = rand_below(32);
            cpu_write(7'(4 * sel), base + 8'(rand_below(24)));
            cpu_write(7'(4 * sel + 1), rand_byte());
            cpu_write(7'(4 * sel + 2), rand_byte());
            cpu_write(7'(4 * sel + 3), rand_byte());
        end
        bus_idle();
        for (int r = 0; r < 40; r++) run_line(base + 8'(r), 1'b1);
        report("rom stall", c0, e0);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: compile.f
src/obj_video_pkg.sv
src/obj_bus_pkg.sv
src/obj_table_ram.sv
src/obj_scan.sv
src/obj_draw.sv
src/obj_line_buf.sv
src/obj_pal_prom.sv
src/obj_engine.sv
verif/tb_clk_gen.sv
verif/tb_obj_engine.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sprite engine testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f compile.f --top-module tb_obj_engine -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Everything OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
